//--- compile.f
hw/l2_cache_pkg.sv
hw/l2_data_if.sv
hw/ram512x128.sv
hw/l2_data_ctrl.sv
hw/l2_data_ram.sv
hw/l2_read_return.sv
hw/l2_data_top.sv
testbench/l2_data_checker.sv
testbench/l2_data_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -O2
TOP       := l2_data_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/l2_data_tb.sv
`timescale 1ns/10ps

module l2_data_tb
    import l2_cache_pkg::*;
();

    localparam int          IDX_W      = 9;
    localparam int          CLK_NS     = 4;
    localparam int          RST_CYCLES = 8;
    localparam int          FILL_CYC   = 64;
    localparam int          L1_CYC     = 96;
    localparam int          ISO_CYC    = 48;     // rounds of 4 fills and 4 reads
    localparam int          B2B_CYC    = 96;     // rounds of 6 commands
    localparam int          DRAIN_CYC  = 4;
    localparam int          MARGIN_CYC = 50;
    localparam int          TOTAL_CYC  = RST_CYCLES + FILL_CYC + L1_CYC + ISO_CYC + B2B_CYC
                                         + DRAIN_CYC;
    localparam int unsigned SEED       = 32'h6586877e;
    localparam int          WINDOW     = 8;      // small index window, addresses get reused
    localparam logic [IDX_W-1:0] IDX_BASE = IDX_W'(160);

    logic                 clk;
    logic                 rst_n;
    cmd_t                 cmd;
    logic [1:0]           way;
    logic [IDX_W-1:0]     index;
    logic [1:0]           offset;
    logic [L2_LINE_W-1:0] wdata_line;
    logic [L2_WORD_W-1:0] wdata_word;
    logic                 rd_valid;
    logic [L2_LINE_W-1:0] rd_line;
    logic [L2_WORD_W-1:0] rd_word;
    logic [1:0]           phase;
    logic [1:0]           cur_phase;
    int                   errors;
    int                   checked;
    int                   reads_issued;

    l2_data_top #(.IDX_W(IDX_W)) u_l2_data_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .way        (way),
        .index      (index),
        .offset     (offset),
        .wdata_line (wdata_line),
        .wdata_word (wdata_word),
        .rd_valid   (rd_valid),
        .rd_line    (rd_line),
        .rd_word    (rd_word)
    );

    l2_data_checker #(.IDX_W(IDX_W)) u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .cmd        (cmd),
        .way        (way),
        .index      (index),
        .offset     (offset),
        .wdata_line (wdata_line),
        .wdata_word (wdata_word),
        .rd_valid   (rd_valid),
        .rd_line    (rd_line),
        .rd_word    (rd_word),
        .errors     (errors),
        .checked    (checked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_CYC + MARGIN_CYC) * CLK_NS);
        $display("timeout: run did not finish within %0d cycles", TOTAL_CYC + MARGIN_CYC);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [L2_WORD_W-1:0] rand_word();
        logic [L2_WORD_W-1:0] w;
        for (int i = 0; i < L2_WORD_W / 32; i++) begin
            w[i*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    function automatic logic [L2_LINE_W-1:0] rand_line();
        l2_line_u l;
        for (int n = 0; n < L2_WORDS; n++) begin
            l.word[n] = rand_word();
        end
        return l.line;
    endfunction

    function automatic logic [IDX_W-1:0] rand_index();
        return IDX_BASE + IDX_W'($urandom % WINDOW);
    endfunction

    // one command per cycle, driven on the falling edge
    task automatic issue(input cmd_t c, input logic [1:0] w, input logic [IDX_W-1:0] idx,
                         input logic [1:0] off);
        @(negedge clk);
        phase      = cur_phase;
        cmd        = c;
        way        = w;
        index      = idx;
        offset     = off;
        wdata_line = rand_line();
        wdata_word = rand_word();
        if (c == CMD_READ) begin
            reads_issued++;
        end
    endtask

    task automatic run_fill_read();
        cur_phase = 2'd0;
        for (int i = 0; i < FILL_CYC / 2; i++) begin
            issue(CMD_FILL, 2'(i), IDX_BASE + IDX_W'(i / L2_WAYS), WORD0);    // whole window
        end
        for (int i = 0; i < FILL_CYC / 2; i++) begin
            issue(CMD_READ, 2'($urandom), rand_index(), 2'($urandom));
        end
    endtask

    task automatic run_l1_write();
        int unsigned r;
        cur_phase = 2'd1;
        for (int i = 0; i < L1_CYC; i++) begin
            r = $urandom % 8;
            if (r < 4) begin
                issue(CMD_L1_WR, 2'($urandom), rand_index(), 2'($urandom));
            end else if (r < 7) begin
                issue(CMD_READ, 2'($urandom), rand_index(), 2'($urandom));
            end else begin
                issue(CMD_NOP, 2'd0, IDX_BASE, WORD0);
            end
        end
    endtask

    task automatic run_way_isolation();
        logic [IDX_W-1:0] idx;
        cur_phase = 2'd2;
        for (int r = 0; r < ISO_CYC / 8; r++) begin
            idx = rand_index();
            for (int w = 0; w < L2_WAYS; w++) begin
                issue(CMD_FILL, 2'(w), idx, WORD0);
            end
            for (int w = 0; w < L2_WAYS; w++) begin
                issue(CMD_READ, 2'(w), idx, 2'($urandom));
            end
        end
    endtask

    // write, read of the same address next cycle, then a burst of reads
    task automatic run_raw_b2b();
        logic [IDX_W-1:0] idx;
        logic [1:0]       w;
        logic [1:0]       off;
        cur_phase = 2'd3;
        for (int r = 0; r < B2B_CYC / 6; r++) begin
            idx = rand_index();
            w   = 2'($urandom);
            off = 2'($urandom);
            if ($urandom % 2 == 0) begin
                issue(CMD_FILL, w, idx, off);
            end else begin
                issue(CMD_L1_WR, w, idx, off);
            end
            issue(CMD_READ, w, idx, off);
            for (int k = 0; k < 4; k++) begin
                issue(CMD_READ, 2'($urandom), rand_index(), 2'($urandom));
            end
        end
    endtask

    initial begin
        int total_errors;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        cmd          = CMD_NOP;
        way          = 2'd0;
        index        = '0;
        offset       = WORD0;
        wdata_line   = '0;
        wdata_word   = '0;
        phase        = 2'd0;
        cur_phase    = 2'd0;
        reads_issued = 0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_fill_read();
        run_l1_write();
        run_way_isolation();
        run_raw_b2b();
        repeat (DRAIN_CYC) begin
            issue(CMD_NOP, 2'd0, IDX_BASE, WORD0);    // let the last reads return
        end
        total_errors = errors;
        if (checked != reads_issued) begin
            $display("only %0d of %0d reads returned data", checked, reads_issued);
            total_errors++;
        end
        $display("errors: %0d, reads checked: %0d", total_errors, checked);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- testbench/l2_data_checker.sv
`timescale 1ns/10ps

module l2_data_checker
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           phase,
    input  cmd_t                 cmd,
    input  logic [1:0]           way,
    input  logic [IDX_W-1:0]     index,
    input  logic [1:0]           offset,
    input  logic [L2_LINE_W-1:0] wdata_line,
    input  logic [L2_WORD_W-1:0] wdata_word,
    input  logic                 rd_valid,
    input  logic [L2_LINE_W-1:0] rd_line,
    input  logic [L2_WORD_W-1:0] rd_word,
    output int                   errors,
    output int                   checked
);

    localparam int DEPTH = 1 << IDX_W;

    typedef struct packed {
        logic [L2_LINE_W-1:0] line;
        logic [L2_WORDS-1:0]  vld;       // word written at least once
        logic [1:0]           offset;
        logic [1:0]           phase;
        int                   issued;    // cycle the read was sampled
    } rd_exp_t;

    logic [L2_WORD_W-1:0] shadow  [L2_WAYS][DEPTH][L2_WORDS];
    bit                   written [L2_WAYS][DEPTH][L2_WORDS];
    rd_exp_t              pend_q [$];
    int                   cycle;

    function automatic string test_name(input logic [1:0] ph);
        case (ph)
            2'd0:    return "fill_read";
            2'd1:    return "l1_write";
            2'd2:    return "way_isolation";
            default: return "raw_back_to_back";
        endcase
    endfunction

    task automatic compare_read(input rd_exp_t e);
        logic [L2_WORD_W-1:0] exp_word;
        for (int n = 0; n < L2_WORDS; n++) begin
            exp_word = e.line[n*L2_WORD_W +: L2_WORD_W];
            if (e.vld[n] && rd_line[n*L2_WORD_W +: L2_WORD_W] !== exp_word) begin
                $display("Fail %s rd_line word %0d expected %h actual %h", test_name(e.phase),
                         n, exp_word, rd_line[n*L2_WORD_W +: L2_WORD_W]);
                errors++;
            end
        end
        exp_word = e.line[int'(e.offset)*L2_WORD_W +: L2_WORD_W];
        if (e.vld[e.offset] && rd_word !== exp_word) begin
            $display("Fail %s rd_word expected %h actual %h", test_name(e.phase),
                     exp_word, rd_word);
            errors++;
        end
    endtask

    // inputs change on the falling edge, so everything is stable here
    always @(posedge clk) begin
        rd_exp_t e;
        cycle++;
        if (!rst_n) begin
            errors  = 0;
            checked = 0;
            pend_q.delete();
        end else begin
            if (rd_valid === 1'b1) begin
                if (pend_q.size() == 0) begin
                    $display("rd_valid seen at cycle %0d with no read outstanding", cycle);
                    errors++;
                end else begin
                    e = pend_q.pop_front();
                    if (cycle - e.issued != 2) begin
                        $display("read from cycle %0d returned after %0d cycles instead of 2",
                                 e.issued, cycle - e.issued);
                        errors++;
                    end
                    compare_read(e);
                    checked++;
                end
            end else if (rd_valid !== 1'b0) begin
                $display("rd_valid is unknown at cycle %0d", cycle);
                errors++;
            end else if (pend_q.size() != 0 && cycle - pend_q[0].issued >= 2) begin
                e = pend_q.pop_front();
                $display("rd_valid missing for %s read issued at cycle %0d",
                         test_name(e.phase), e.issued);
                errors++;
            end
            case (cmd)
                CMD_FILL: begin
                    for (int n = 0; n < L2_WORDS; n++) begin
                        shadow[way][index][n]  = wdata_line[n*L2_WORD_W +: L2_WORD_W];
                        written[way][index][n] = 1'b1;
                    end
                end
                CMD_L1_WR: begin
                    shadow[way][index][offset]  = wdata_word;
                    written[way][index][offset] = 1'b1;
                end
                CMD_READ: begin
                    for (int n = 0; n < L2_WORDS; n++) begin
                        e.line[n*L2_WORD_W +: L2_WORD_W] = shadow[way][index][n];
                        e.vld[n] = written[way][index][n];
                    end
                    e.offset = offset;
                    e.phase  = phase;
                    e.issued = cycle;
                    pend_q.push_back(e);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- hw/l2_data_top.sv
`timescale 1ns/10ps

module l2_data_top
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cmd_t                 cmd,
    input  logic [1:0]           way,
    input  logic [IDX_W-1:0]     index,
    input  logic [1:0]           offset,
    input  logic [L2_LINE_W-1:0] wdata_line,
    input  logic [L2_WORD_W-1:0] wdata_word,
    output logic                 rd_valid,
    output logic [L2_LINE_W-1:0] rd_line,
    output logic [L2_WORD_W-1:0] rd_word
);

    logic                 rd_pend;
    logic [1:0]           rd_way;
    logic [1:0]           rd_offset;
    logic [L2_LINE_W-1:0] data0_rd;
    logic [L2_LINE_W-1:0] data1_rd;
    logic [L2_LINE_W-1:0] data2_rd;
    logic [L2_LINE_W-1:0] data3_rd;

    l2_data_if #(.IDX_W(IDX_W)) u_bus ();

    l2_data_ctrl #(
        .IDX_W (IDX_W)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .way        (way),
        .index      (index),
        .offset     (offset),
        .wdata_line (wdata_line),
        .wdata_word (wdata_word),
        .bus        (u_bus.ctrl),
        .rd_pend    (rd_pend),
        .rd_way     (rd_way),
        .rd_offset  (rd_offset)
    );

    l2_data_ram #(
        .IDX_W (IDX_W)
    ) u_ram (
        .clk      (clk),
        .bus      (u_bus.array),
        .data0_rd (data0_rd),
        .data1_rd (data1_rd),
        .data2_rd (data2_rd),
        .data3_rd (data3_rd)
    );

    l2_read_return u_ret (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_pend   (rd_pend),
        .rd_way    (rd_way),
        .rd_offset (rd_offset),
        .data0_rd  (data0_rd),
        .data1_rd  (data1_rd),
        .data2_rd  (data2_rd),
        .data3_rd  (data3_rd),
        .rd_valid  (rd_valid),
        .rd_line   (rd_line),
        .rd_word   (rd_word)
    );

endmodule

//--- hw/l2_read_return.sv
`timescale 1ns/10ps

module l2_read_return
    import l2_cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd_pend,
    input  logic [1:0]           rd_way,
    input  logic [1:0]           rd_offset,
    input  logic [L2_LINE_W-1:0] data0_rd,
    input  logic [L2_LINE_W-1:0] data1_rd,
    input  logic [L2_LINE_W-1:0] data2_rd,
    input  logic [L2_LINE_W-1:0] data3_rd,
    output logic                 rd_valid,
    output logic [L2_LINE_W-1:0] rd_line,
    output logic [L2_WORD_W-1:0] rd_word
);

    l2_line_u sel_line;

    // way mux on bank outputs
    always_comb begin
        case (rd_way)
            2'd0:    sel_line.line = data0_rd;
            2'd1:    sel_line.line = data1_rd;
            2'd2:    sel_line.line = data2_rd;
            default: sel_line.line = data3_rd;
        endcase
    end

    // result holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= DISABLE;
            rd_line  <= '0;
            rd_word  <= '0;
        end else begin
            rd_valid <= rd_pend;    // one-cycle pulse per read
            if (rd_pend == ENABLE) begin
                rd_line <= sel_line.line;
                rd_word <= sel_line.word[rd_offset];
            end
        end
    end

endmodule

//--- hw/l2_data_ram.sv
`timescale 1ns/10ps

module l2_data_ram
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
) (
    input  logic                 clk,
    l2_data_if.array             bus,
    output logic [L2_LINE_W-1:0] data0_rd,    // way 0 read line
    output logic [L2_LINE_W-1:0] data1_rd,    // way 1 read line
    output logic [L2_LINE_W-1:0] data2_rd,    // way 2 read line
    output logic [L2_LINE_W-1:0] data3_rd     // way 3 read line
);

    logic [L2_WAYS-1:0][L2_WORDS-1:0] wr_en;    // per bank write enable
    logic [L2_WORDS-1:0]              word_sel;  // one-hot from offset
    logic [L2_WAYS-1:0][L2_LINE_W-1:0] way_q;

    always_comb begin
        case (bus.offset)
            WORD0:   word_sel = 4'b0001;
            WORD1:   word_sel = 4'b0010;
            WORD2:   word_sel = 4'b0100;
            WORD3:   word_sel = 4'b1000;
            default: word_sel = 4'b0000;
        endcase
    end

    // write enable decode
    always_comb begin
        logic l1_done;
        l1_done = DISABLE;
        wr_en   = '0;
        if (bus.mem_wr_en == ENABLE) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                if (bus.block_we[w] == ENABLE) begin
                    wr_en[w] = '1;    // whole line
                end
            end
        end else if (bus.l1_wr_en == ENABLE) begin
            // only the lowest selected way takes the word
            for (int w = 0; w < L2_WAYS; w++) begin
                if (bus.block_we[w] == ENABLE && l1_done == DISABLE) begin
                    wr_en[w] = word_sel;
                    l1_done  = ENABLE;
                end
            end
        end
    end

    // four banks per way, one word each, sharing the way read enable
    for (genvar w = 0; w < L2_WAYS; w++) begin : g_way
        for (genvar n = 0; n < L2_WORDS; n++) begin : g_word
            ram512x128 #(
                .IDX_W (IDX_W)
            ) u_bank (
                .clock   (clk),
                .address (bus.index),
                .wren    (wr_en[w][n]),
                .rden    (bus.block_re[w]),
                .data    (bus.wdata.word[n]),
                .q       (way_q[w][n*L2_WORD_W +: L2_WORD_W])
            );
        end
    end

    assign data0_rd = way_q[0];
    assign data1_rd = way_q[1];
    assign data2_rd = way_q[2];
    assign data3_rd = way_q[3];

endmodule

//--- hw/l2_data_ctrl.sv
`timescale 1ns/10ps

module l2_data_ctrl
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cmd_t                 cmd,
    input  logic [1:0]           way,
    input  logic [IDX_W-1:0]     index,
    input  logic [1:0]           offset,
    input  logic [L2_LINE_W-1:0] wdata_line,
    input  logic [L2_WORD_W-1:0] wdata_word,
    l2_data_if.ctrl              bus,
    output logic                 rd_pend,
    output logic [1:0]           rd_way,
    output logic [1:0]           rd_offset
);

    logic rd_cmd;

    assign rd_cmd = (cmd == CMD_READ);

    // command decode, all combinational so banks see it at the sampling edge
    always_comb begin
        bus.index      = index;
        bus.offset     = offset;
        bus.wdata.line = wdata_line;
        bus.mem_wr_en  = DISABLE;
        bus.l1_wr_en   = DISABLE;
        bus.block_we   = '0;
        bus.block_re   = '0;
        case (cmd)
            CMD_FILL: begin
                bus.mem_wr_en     = ENABLE;
                bus.block_we[way] = ENABLE;
            end
            CMD_L1_WR: begin
                // same word in every slot, array picks the offset one
                bus.wdata.line    = {L2_WORDS{wdata_word}};
                bus.l1_wr_en      = ENABLE;
                bus.block_we[way] = ENABLE;
            end
            CMD_READ: begin
                bus.block_re[way] = ENABLE;
            end
            default: begin
            end
        endcase
    end

    // marks the cycle when bank q holds the read data
    // way and offset follow the read by one stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend   <= DISABLE;
            rd_way    <= '0;
            rd_offset <= WORD0;
        end else begin
            rd_pend <= rd_cmd;
            if (rd_cmd) begin
                rd_way    <= way;
                rd_offset <= offset;
            end
        end
    end

endmodule

//--- hw/ram512x128.sv
`timescale 1ns/10ps

module ram512x128
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
) (
    input  logic                 clock,
    input  logic [IDX_W-1:0]     address,
    input  logic                 wren,
    input  logic                 rden,
    input  logic [L2_WORD_W-1:0] data,
    output logic [L2_WORD_W-1:0] q
);

    localparam int DEPTH = 1 << IDX_W;

    logic [L2_WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clock) begin
        if (wren == ENABLE) begin
            mem[address] <= data;
        end
    end

    // registered read port, holds while rden is low
    always_ff @(posedge clock) begin
        if (rden == ENABLE) begin
            q <= mem[address];
        end
    end

endmodule

//--- hw/l2_data_if.sv
`timescale 1ns/10ps

interface l2_data_if
    import l2_cache_pkg::*;
#(
    parameter int IDX_W = 9
);

    logic [IDX_W-1:0]   index;
    logic [1:0]         offset;      // word select for L1 writes
    l2_line_u           wdata;
    logic               mem_wr_en;   // fill strobe
    logic               l1_wr_en;    // L1 write-back strobe
    logic [L2_WAYS-1:0] block_we;    // one-hot way write select
    logic [L2_WAYS-1:0] block_re;    // one-hot way read select

    modport ctrl (
        output index,
        output offset,
        output wdata,
        output mem_wr_en,
        output l1_wr_en,
        output block_we,
        output block_re
    );

    modport array (
        input  index,
        input  offset,
        input  wdata,
        input  mem_wr_en,
        input  l1_wr_en,
        input  block_we,
        input  block_re
    );

endinterface

//--- hw/l2_cache_pkg.sv
package l2_cache_pkg;

    // line geometry
    localparam int L2_WAYS   = 4;
    localparam int L2_WORDS  = 4;                       // 128-bit words per line
    localparam int L2_WORD_W = 128;
    localparam int L2_LINE_W = L2_WORDS * L2_WORD_W;    // 512

    // generic strobe levels, all active high
    localparam logic ENABLE  = 1'b1;
    localparam logic DISABLE = 1'b0;

    // command codes on the top level port
    typedef logic [1:0] cmd_t;

    localparam cmd_t CMD_NOP   = 2'd0;                  // idle
    localparam cmd_t CMD_FILL  = 2'd1;                  // whole line from memory
    localparam cmd_t CMD_L1_WR = 2'd2;                  // one word written back by L1
    localparam cmd_t CMD_READ  = 2'd3;                  // line read

    // word offset within a line
    localparam logic [1:0] WORD0 = 2'd0;
    localparam logic [1:0] WORD1 = 2'd1;
    localparam logic [1:0] WORD2 = 2'd2;
    localparam logic [1:0] WORD3 = 2'd3;

    // A line is used whole for fills and reads, and word by word for
    // L1 write-backs and word returns. word[0] sits in the lowest bits.
    typedef union packed {
        logic [L2_LINE_W-1:0]               line;
        logic [L2_WORDS-1:0][L2_WORD_W-1:0] word;
    } l2_line_u;

endpackage
